// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_rv64_exec
DUT_TOP    := rv64_exec
FILELIST   := rv64_exec.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: design/alu_op_pkg.sv
`default_nettype none

package alu_op_pkg;

    // operation codes, unused encodings give zero
    typedef enum logic [4:0] {
        op_add    = 5'd0,
        op_sub    = 5'd1,
        op_pass_a = 5'd2,
        op_pass_b = 5'd3,
        op_xor    = 5'd4,
        op_or     = 5'd5,
        op_and    = 5'd6,
        op_sll    = 5'd7,
        op_srl    = 5'd8,
        op_sra    = 5'd9,
        op_slt    = 5'd10,
        op_sltu   = 5'd11,
        op_eq     = 5'd12,
        op_ge     = 5'd13,
        op_geu    = 5'd14,
        op_mul    = 5'd15
    } alu_op_e;

    // second operand source
    typedef enum logic [1:0] {
        src_b_imm = 2'd0,
        src_b_rs2 = 2'd1,
        src_b_csr = 2'd2
    } src_b_e;

    // execute control states
    typedef enum logic {
        st_idle = 1'b0,
        st_mul  = 1'b1
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: design/exec_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl #(
    parameter int MUL_STEP = 2
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    issue,
    input  logic                    flush,
    input  alu_op_pkg::alu_op_e     op,
    input  rv_word_pkg::xlen_word_t pc,
    input  rv_word_pkg::xlen_word_t rs1,
    input  rv_word_pkg::xlen_word_t rs2,
    input  rv_word_pkg::xlen_word_t csr,
    input  rv_word_pkg::xlen_word_t imm,
    input  logic                    sel_a_rs1,
    input  alu_op_pkg::src_b_e      sel_b,
    input  logic                    word32,
    output rv_word_pkg::xlen_word_t res,
    output logic                    res_valid,
    output logic                    busy,
    // integer unit side
    output rv_word_pkg::xlen_word_t operand_a,
    output rv_word_pkg::xlen_word_t operand_b,
    output alu_op_pkg::alu_op_e     alu_op,
    output logic                    alu_word32,
    input  rv_word_pkg::xlen_word_t alu_res,
    mul_if.ctrl                     mul
);

    alu_op_pkg::ctrl_state_e state;
    logic                    is_mul;

    // the stall window is 64/MUL_STEP + 1 cycles, step must divide 64
    if (MUL_STEP != 1 && MUL_STEP != 2 && MUL_STEP != 4) begin : g_bad_step
        $error("exec_ctrl: MUL_STEP must be 1, 2 or 4");
    end

    // operand a, rs1 zero-extended in word mode
    assign operand_a = sel_a_rs1 ? (word32 ? {32'd0, rs1[31:0]} : rs1) : pc;

    always_comb begin
        case (sel_b)
            alu_op_pkg::src_b_rs2: operand_b = rs2;
            alu_op_pkg::src_b_csr: operand_b = csr;
            default:               operand_b = imm;
        endcase
    end

    assign alu_op     = op;
    assign alu_word32 = word32;
    assign is_mul     = op == alu_op_pkg::op_mul;

    // start loads at the issue edge itself
    assign mul.start        = issue && is_mul && (state == alu_op_pkg::st_idle);
    // no abort once the unit has finished iterating
    assign mul.abort        = flush && mul.busy && (state == alu_op_pkg::st_mul);
    assign mul.multiplicand = operand_a;
    assign mul.multiplier   = operand_b;

    assign busy = state == alu_op_pkg::st_mul;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= alu_op_pkg::st_idle;
            res       <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            case (state)
                alu_op_pkg::st_idle: begin
                    if (issue) begin
                        if (is_mul) begin
                            state <= alu_op_pkg::st_mul;
                        end else begin
                            res       <= alu_res;
                            res_valid <= 1'b1;
                        end
                    end
                end
                alu_op_pkg::st_mul: begin
                    // flush wins over a finishing multiply
                    if (flush) begin
                        state <= alu_op_pkg::st_idle;
                    end else if (mul.done) begin
                        res       <= mul.product;
                        res_valid <= 1'b1;
                        state     <= alu_op_pkg::st_idle;
                    end
                end
                default: begin
                    state <= alu_op_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu (
    input  alu_op_pkg::alu_op_e     op,
    input  rv_word_pkg::xlen_word_t operand_a,
    input  rv_word_pkg::xlen_word_t operand_b,
    input  logic                    word32,
    output rv_word_pkg::xlen_word_t alu_res
);

    rv_word_pkg::shamt_t shamt;
    logic [31:0]         sra_low;
    logic                lt_s;
    logic                lt_u;
    logic                eq;

    assign shamt = operand_b[5:0];

    // word mode arithmetic shift on the low half only
    assign sra_low = $signed(operand_a[31:0]) >>> shamt;

    assign lt_s = $signed(operand_a) < $signed(operand_b);
    assign lt_u = operand_a < operand_b;
    assign eq   = operand_a == operand_b;

    always_comb begin
        case (op)
            alu_op_pkg::op_add: begin
                alu_res = operand_a + operand_b;
            end
            alu_op_pkg::op_sub: begin
                alu_res = operand_a - operand_b;
            end
            alu_op_pkg::op_pass_a: begin
                alu_res = operand_a;
            end
            alu_op_pkg::op_pass_b: begin
                alu_res = operand_b;
            end
            alu_op_pkg::op_xor: begin
                alu_res = operand_a ^ operand_b;
            end
            alu_op_pkg::op_or: begin
                alu_res = operand_a | operand_b;
            end
            alu_op_pkg::op_and: begin
                alu_res = operand_a & operand_b;
            end
            alu_op_pkg::op_sll: begin
                alu_res = operand_a << shamt;
            end
            alu_op_pkg::op_srl: begin
                alu_res = operand_a >> shamt;
            end
            alu_op_pkg::op_sra: begin
                // zero-extended in word mode
                if (word32) begin
                    alu_res = {32'd0, sra_low};
                end else begin
                    alu_res = $signed(operand_a) >>> shamt;
                end
            end
            // comparisons return 1 or 0
            alu_op_pkg::op_slt:  alu_res = {63'd0, lt_s};
            alu_op_pkg::op_sltu: alu_res = {63'd0, lt_u};
            alu_op_pkg::op_eq:   alu_res = {63'd0, eq};
            alu_op_pkg::op_ge:   alu_res = {63'd0, ~lt_s};
            alu_op_pkg::op_geu:  alu_res = {63'd0, ~lt_u};
            // mul is handled by the multiplier
            default: begin
                alu_res = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/mul_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mul_if;

    // request side, driven by the control block
    logic                    start;
    logic                    abort;
    rv_word_pkg::xlen_word_t multiplicand;
    rv_word_pkg::xlen_word_t multiplier;

    // response side, driven by the multiplier
    logic                    busy;
    logic                    done;
    rv_word_pkg::xlen_word_t product;

    modport ctrl (
        output start, abort, multiplicand, multiplier,
        input  busy, done, product
    );

    modport unit (
        input  start, abort, multiplicand, multiplier,
        output busy, done, product
    );

endinterface

`default_nettype wire

// File: design/rv64_exec.sv
`timescale 1ns/1ps
`default_nettype none

module rv64_exec #(
    parameter int MUL_STEP = 2
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    issue,
    input  logic                    flush,
    input  alu_op_pkg::alu_op_e     op,
    input  rv_word_pkg::xlen_word_t pc,
    input  rv_word_pkg::xlen_word_t rs1,
    input  rv_word_pkg::xlen_word_t rs2,
    input  rv_word_pkg::xlen_word_t csr,
    input  rv_word_pkg::xlen_word_t imm,
    input  logic                    sel_a_rs1,
    input  alu_op_pkg::src_b_e      sel_b,
    input  logic                    word32,
    output rv_word_pkg::xlen_word_t res,
    output logic                    res_valid,
    output logic                    busy
);

    rv_word_pkg::xlen_word_t operand_a;
    rv_word_pkg::xlen_word_t operand_b;
    rv_word_pkg::xlen_word_t alu_res;
    alu_op_pkg::alu_op_e     alu_op;
    logic                    alu_word32;

    mul_if u_mul_if ();

    int_alu u_int_alu (
        .op        (alu_op),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .word32    (alu_word32),
        .alu_res   (alu_res)
    );

    shift_add_mul #(
        .MUL_STEP (MUL_STEP)
    ) u_shift_add_mul (
        .clk    (clk),
        .arst_n (arst_n),
        .mul    (u_mul_if.unit)
    );

    exec_ctrl #(
        .MUL_STEP (MUL_STEP)
    ) u_exec_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .issue      (issue),
        .flush      (flush),
        .op         (op),
        .pc         (pc),
        .rs1        (rs1),
        .rs2        (rs2),
        .csr        (csr),
        .imm        (imm),
        .sel_a_rs1  (sel_a_rs1),
        .sel_b      (sel_b),
        .word32     (word32),
        .res        (res),
        .res_valid  (res_valid),
        .busy       (busy),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .alu_op     (alu_op),
        .alu_word32 (alu_word32),
        .alu_res    (alu_res),
        .mul        (u_mul_if.ctrl)
    );

endmodule

`default_nettype wire

// File: design/rv_word_pkg.sv
`default_nettype none

package rv_word_pkg;

    // machine word width of the datapath
    localparam int XLEN = 64;

    // operand or result word
    typedef logic [XLEN-1:0] xlen_word_t;

    // shift amount, low six bits of operand b
    typedef logic [5:0] shamt_t;

    // multiplier step counter, holds up to 64 steps
    typedef logic [6:0] mul_count_t;

endpackage

`default_nettype wire

// File: design/shift_add_mul.sv
`timescale 1ns/1ps
`default_nettype none

module shift_add_mul #(
    parameter int MUL_STEP = 2
) (
    input  logic      clk,
    input  logic      arst_n,
    mul_if.unit       mul
);

    // number of steps for a full 64-bit multiplier
    localparam rv_word_pkg::mul_count_t STEPS =
        rv_word_pkg::mul_count_t'(rv_word_pkg::XLEN / MUL_STEP);

    rv_word_pkg::xlen_word_t acc;
    rv_word_pkg::xlen_word_t mcand;
    rv_word_pkg::xlen_word_t mplier;
    rv_word_pkg::xlen_word_t step_acc;
    rv_word_pkg::mul_count_t count;
    logic                    running;
    logic                    done_q;

    // add MUL_STEP partial products, upper bits fall off
    always_comb begin
        step_acc = acc;
        for (int i = 0; i < MUL_STEP; i++) begin
            if (mplier[i]) begin
                step_acc = step_acc + (mcand << i);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
            done_q  <= 1'b0;
            count   <= '0;
        end else begin
            done_q <= 1'b0;
            if (mul.abort) begin
                running <= 1'b0;
                count   <= '0;
            end else if (mul.start) begin
                running <= 1'b1;
                count   <= STEPS;
            end else if (running) begin
                count <= count - rv_word_pkg::mul_count_t'(1);
                // last step, product is final at this edge
                if (count == rv_word_pkg::mul_count_t'(1)) begin
                    running <= 1'b0;
                    done_q  <= 1'b1;
                end
            end
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        if (mul.start) begin
            acc    <= '0;
            mcand  <= mul.multiplicand;
            mplier <= mul.multiplier;
        end else if (running) begin
            acc    <= step_acc;
            mcand  <= mcand << MUL_STEP;
            mplier <= mplier >> MUL_STEP;
        end
    end

    assign mul.busy    = running;
    assign mul.done    = done_q;
    assign mul.product = acc;

endmodule

`default_nettype wire

// File: rv64_exec.f
design/rv_word_pkg.sv
design/alu_op_pkg.sv
design/mul_if.sv
design/int_alu.sv
design/shift_add_mul.sv
design/exec_ctrl.sv
design/rv64_exec.sv
sim/exec_clk_gen.sv
sim/exec_checker.sv
sim/tb_rv64_exec.sv

// File: sim/exec_checker.sv
`timescale 1ns/1ps
`default_nettype none

module exec_checker (
    input logic                clk,
    input logic                arst_n,
    input logic                issue,
    input logic                flush,
    input alu_op_pkg::alu_op_e op,
    input logic                busy,
    input logic                res_valid,
    input logic                start,
    input logic                abort,
    input logic                unit_busy
);

    int fail_count = 0;

    // busy only rises one edge after a mul issue
    busy_after_mul: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(busy) |-> $past(issue && op == alu_op_pkg::op_mul))
    else begin
        fail_count++;
        $error("busy rose without a mul issue");
    end

    // busy ends with the multiply result or after a flush
    busy_ends_with_result: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> res_valid || $past(flush))
    else begin
        fail_count++;
        $error("busy fell without a result or a flush");
    end

    start_single_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        start |=> !start)
    else begin
        fail_count++;
        $error("multiplier start held longer than one cycle");
    end

    // abort clears the stage and the unit, with no result
    abort_clears_unit: assert property (@(posedge clk) disable iff (!arst_n)
        abort |=> !busy && !unit_busy && !res_valid)
    else begin
        fail_count++;
        $error("abort did not clear busy without a result");
    end

endmodule

bind exec_ctrl exec_checker u_exec_checker (
    .clk       (clk),
    .arst_n    (arst_n),
    .issue     (issue),
    .flush     (flush),
    .op        (op),
    .busy      (busy),
    .res_valid (res_valid),
    .start     (mul.start),
    .abort     (mul.abort),
    .unit_busy (mul.busy)
);

`default_nettype wire

// File: sim/exec_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module exec_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/tb_rv64_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv64_exec;

    localparam int MUL_STEP = 2;
    localparam int STEPS    = 64 / MUL_STEP;

    typedef struct packed {
        alu_op_pkg::alu_op_e     op;
        rv_word_pkg::xlen_word_t pc;
        rv_word_pkg::xlen_word_t rs1;
        rv_word_pkg::xlen_word_t rs2;
        rv_word_pkg::xlen_word_t csr;
        rv_word_pkg::xlen_word_t imm;
        logic                    sel_a_rs1;
        alu_op_pkg::src_b_e      sel_b;
        logic                    word32;
        int                      flush_after;
        rv_word_pkg::xlen_word_t expected;
    } row_t;

    logic                    clk;
    logic                    arst_n;
    logic                    issue;
    logic                    flush;
    logic                    sel_a_rs1;
    logic                    word32;
    logic                    res_valid;
    logic                    busy;
    alu_op_pkg::alu_op_e     op;
    alu_op_pkg::src_b_e      sel_b;
    rv_word_pkg::xlen_word_t pc;
    rv_word_pkg::xlen_word_t rs1;
    rv_word_pkg::xlen_word_t rs2;
    rv_word_pkg::xlen_word_t csr;
    rv_word_pkg::xlen_word_t imm;
    rv_word_pkg::xlen_word_t res;

    // operand values picked up by the next table row
    rv_word_pkg::xlen_word_t v_pc;
    rv_word_pkg::xlen_word_t v_rs1;
    rv_word_pkg::xlen_word_t v_rs2;
    rv_word_pkg::xlen_word_t v_csr;
    rv_word_pkg::xlen_word_t v_imm;
    rv_word_pkg::xlen_word_t last_res;

    row_t table_q[$];
    int   errors      = 0;
    int   checks      = 0;
    int   cycle_count = 0;
    int   cycle_limit = 0;

    exec_clk_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (2)
    ) u_exec_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    rv64_exec #(
        .MUL_STEP (MUL_STEP)
    ) u_rv64_exec (
        .clk       (clk),
        .arst_n    (arst_n),
        .issue     (issue),
        .flush     (flush),
        .op        (op),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .csr       (csr),
        .imm       (imm),
        .sel_a_rs1 (sel_a_rs1),
        .sel_b     (sel_b),
        .word32    (word32),
        .res       (res),
        .res_valid (res_valid),
        .busy      (busy)
    );

    function automatic rv_word_pkg::xlen_word_t ref_result(input row_t r);
        rv_word_pkg::xlen_word_t a;
        rv_word_pkg::xlen_word_t b;
        rv_word_pkg::xlen_word_t y;
        rv_word_pkg::xlen_word_t flip;
        logic [31:0]             low;
        logic [5:0]              sh;
        flip = 64'h8000_0000_0000_0000;
        a = r.sel_a_rs1 ? r.rs1 : r.pc;
        if (r.sel_a_rs1 && r.word32) begin
            a = {32'd0, r.rs1[31:0]};
        end
        case (r.sel_b)
            alu_op_pkg::src_b_rs2: b = r.rs2;
            alu_op_pkg::src_b_csr: b = r.csr;
            default:               b = r.imm;
        endcase
        sh  = b[5:0];
        low = a[31:0];
        case (r.op)
            alu_op_pkg::op_add:    y = a + b;
            alu_op_pkg::op_sub:    y = a - b;
            alu_op_pkg::op_pass_a: y = a;
            alu_op_pkg::op_pass_b: y = b;
            alu_op_pkg::op_xor:    y = a ^ b;
            alu_op_pkg::op_or:     y = a | b;
            alu_op_pkg::op_and:    y = a & b;
            alu_op_pkg::op_sll:    y = a << sh;
            alu_op_pkg::op_srl:    y = a >> sh;
            alu_op_pkg::op_sra: begin
                // logical shift, then fill the vacated bits with the sign
                if (r.word32) begin
                    y = {32'd0, (low >> sh) | (low[31] ? ~(32'hFFFF_FFFF >> sh) : 32'd0)};
                end else begin
                    y = (a >> sh) | (a[63] ? ~({64{1'b1}} >> sh) : 64'd0);
                end
            end
            alu_op_pkg::op_slt:    y = {63'd0, (a ^ flip) < (b ^ flip)};
            alu_op_pkg::op_sltu:   y = {63'd0, a < b};
            alu_op_pkg::op_eq:     y = {63'd0, a == b};
            alu_op_pkg::op_ge:     y = {63'd0, (a ^ flip) >= (b ^ flip)};
            alu_op_pkg::op_geu:    y = {63'd0, a >= b};
            alu_op_pkg::op_mul:    y = a * b;
            default:               y = '0;
        endcase
        return y;
    endfunction

    function automatic rv_word_pkg::xlen_word_t random_word();
        return {$urandom, $urandom};
    endfunction

    task automatic add_row(input alu_op_pkg::alu_op_e op_v, input logic sel_a,
                           input alu_op_pkg::src_b_e sel_b_v, input logic w32,
                           input int flush_after);
        row_t r;
        r.op          = op_v;
        r.pc          = v_pc;
        r.rs1         = v_rs1;
        r.rs2         = v_rs2;
        r.csr         = v_csr;
        r.imm         = v_imm;
        r.sel_a_rs1   = sel_a;
        r.sel_b       = sel_b_v;
        r.word32      = w32;
        r.flush_after = flush_after;
        // a flushed multiply leaves the previous result in place
        if (op_v == alu_op_pkg::op_mul && flush_after > 0) begin
            r.expected = last_res;
        end else begin
            r.expected = ref_result(r);
            last_res   = r.expected;
        end
        table_q.push_back(r);
    endtask

    task automatic build_table();
        alu_op_pkg::alu_op_e o;
        int                  shifts[6];
        shifts = '{0, 5, 31, 32, 45, 63};
        v_pc  = 64'h0000_0000_8000_1000;
        v_rs1 = 64'hF0F0_1234_8765_4321;
        v_rs2 = 64'h0000_0000_0000_0025;
        v_csr = 64'hFFFF_FFFF_FFFF_FFF0;
        v_imm = 64'h0000_0000_0000_0007;
        // every single-cycle op against every operand select
        for (int i = 0; i < 15; i++) begin
            o = alu_op_pkg::alu_op_e'(5'(i));
            for (int s = 0; s < 2; s++) begin
                add_row(o, s[0], alu_op_pkg::src_b_rs2, 1'b0, 0);
                add_row(o, s[0], alu_op_pkg::src_b_csr, 1'b0, 0);
                add_row(o, s[0], alu_op_pkg::src_b_imm, 1'b0, 0);
            end
        end
        // word mode, negative and positive low halves
        add_row(alu_op_pkg::op_pass_a, 1'b1, alu_op_pkg::src_b_imm, 1'b1, 0);
        add_row(alu_op_pkg::op_add, 1'b1, alu_op_pkg::src_b_csr, 1'b1, 0);
        add_row(alu_op_pkg::op_pass_a, 1'b0, alu_op_pkg::src_b_imm, 1'b1, 0);
        foreach (shifts[k]) begin
            v_rs2 = 64'(shifts[k]);
            v_rs1 = 64'hF0F0_1234_8765_4321;
            add_row(alu_op_pkg::op_sra, 1'b1, alu_op_pkg::src_b_rs2, 1'b1, 0);
            v_rs1 = 64'h8000_0000_7654_3210;
            add_row(alu_op_pkg::op_sra, 1'b1, alu_op_pkg::src_b_rs2, 1'b1, 0);
        end
        // equal operands for the comparisons
        v_rs2 = v_rs1;
        add_row(alu_op_pkg::op_eq, 1'b1, alu_op_pkg::src_b_rs2, 1'b0, 0);
        add_row(alu_op_pkg::op_ge, 1'b1, alu_op_pkg::src_b_rs2, 1'b0, 0);
        add_row(alu_op_pkg::op_geu, 1'b1, alu_op_pkg::src_b_rs2, 1'b0, 0);
        add_row(alu_op_pkg::op_slt, 1'b1, alu_op_pkg::src_b_rs2, 1'b0, 0);
        add_row(alu_op_pkg::alu_op_e'(5'd20), 1'b1, alu_op_pkg::src_b_rs2, 1'b0, 0);
        // directed multiplies
        v_rs1 = 64'd3;
        v_rs2 = 64'd7;
        add_row(alu_op_pkg::op_mul, 1'b1, alu_op_pkg::src_b_rs2, 1'b0, 0);
        v_rs1 = {64{1'b1}};
        v_imm = 64'd5;
        add_row(alu_op_pkg::op_mul, 1'b1, alu_op_pkg::src_b_imm, 1'b0, 0);
        add_row(alu_op_pkg::op_mul, 1'b1, alu_op_pkg::src_b_imm, 1'b1, 0);
        add_row(alu_op_pkg::op_mul, 1'b0, alu_op_pkg::src_b_csr, 1'b0, 0);
        // flush early, midway and on the last step
        add_row(alu_op_pkg::op_mul, 1'b1, alu_op_pkg::src_b_csr, 1'b0, 1);
        add_row(alu_op_pkg::op_add, 1'b1, alu_op_pkg::src_b_imm, 1'b0, 0);
        add_row(alu_op_pkg::op_mul, 1'b1, alu_op_pkg::src_b_rs2, 1'b0, 9);
        add_row(alu_op_pkg::op_mul, 1'b0, alu_op_pkg::src_b_imm, 1'b0, 0);
        add_row(alu_op_pkg::op_mul, 1'b1, alu_op_pkg::src_b_csr, 1'b0, STEPS);
        add_row(alu_op_pkg::op_xor, 1'b1, alu_op_pkg::src_b_csr, 1'b0, 0);
        for (int i = 0; i < 16; i++) begin
            v_pc  = random_word();
            v_rs1 = random_word();
            v_rs2 = random_word();
            v_csr = random_word();
            v_imm = random_word();
            if (i < 4) begin
                o = alu_op_pkg::op_mul;
            end else begin
                o = alu_op_pkg::alu_op_e'(5'($urandom_range(14, 0)));
            end
            add_row(o, $urandom_range(1, 0) == 1,
                    alu_op_pkg::src_b_e'(2'($urandom_range(2, 0))),
                    $urandom_range(1, 0) == 1, 0);
        end
    endtask

    task automatic verify_word(input string name, input rv_word_pkg::xlen_word_t actual,
                               input rv_word_pkg::xlen_word_t expected);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic expect_level(input string name, input logic actual, input logic expected);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERROR at %0t: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic drive_inputs(input row_t r);
        op        = r.op;
        pc        = r.pc;
        rs1       = r.rs1;
        rs2       = r.rs2;
        csr       = r.csr;
        imm       = r.imm;
        sel_a_rs1 = r.sel_a_rs1;
        sel_b     = r.sel_b;
        word32    = r.word32;
    endtask

    task automatic run_row(input row_t r);
        @(negedge clk);
        drive_inputs(r);
        issue = 1'b1;
        @(negedge clk);
        issue = 1'b0;
        if (r.op != alu_op_pkg::op_mul) begin
            expect_level("res_valid", res_valid, 1'b1);
            expect_level("busy", busy, 1'b0);
            verify_word("res", res, r.expected);
        end else if (r.flush_after == 0) begin
            // keep issuing another op during the stall
            op    = alu_op_pkg::op_sub;
            issue = 1'b1;
            while (res_valid !== 1'b1) begin
                expect_level("busy", busy, 1'b1);
                @(negedge clk);
            end
            issue = 1'b0;
            expect_level("busy", busy, 1'b0);
            verify_word("res", res, r.expected);
            @(negedge clk);
            expect_level("res_valid", res_valid, 1'b0);
        end else begin
            for (int k = 1; k < r.flush_after; k++) begin
                expect_level("busy", busy, 1'b1);
                @(negedge clk);
            end
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            expect_level("busy", busy, 1'b0);
            verify_word("res", res, r.expected);
            repeat (STEPS + 2) begin
                expect_level("res_valid", res_valid, 1'b0);
                @(negedge clk);
            end
        end
    endtask

    initial begin
        void'($urandom(29));
        issue     = 1'b0;
        flush     = 1'b0;
        op        = alu_op_pkg::op_add;
        pc        = '0;
        rs1       = '0;
        rs2       = '0;
        csr       = '0;
        imm       = '0;
        sel_a_rs1 = 1'b0;
        sel_b     = alu_op_pkg::src_b_rs2;
        word32    = 1'b0;
        last_res  = '0;
        build_table();
        cycle_limit = table_q.size() * 40 + 100;
        wait (arst_n === 1'b1);
        foreach (table_q[i]) begin
            run_row(table_q[i]);
        end
        $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 u_rv64_exec.u_exec_ctrl.u_exec_checker.fail_count);
        if (errors == 0 && u_rv64_exec.u_exec_ctrl.u_exec_checker.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog on the total cycle budget
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
